//--- axil_periph.f
axil_periph_pkg.sv
event_counter.sv
reg_bank.sv
axil_slave.sv
axil_periph_top.sv
tb_axil_periph.sv

//--- axil_periph_pkg.sv
package axil_periph_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Register map, byte addresses
  localparam logic [ADDR_W-1:0] ADDR_CONTROL = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] ADDR_STATUS  = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] ADDR_COMPARE = 32'h0000_0008;
  localparam logic [ADDR_W-1:0] ADDR_COUNT   = 32'h0000_000C;

  // Control register bits
  localparam int unsigned CTRL_EN_BIT     = 0;
  // Write-only pulse, never stored
  localparam int unsigned CTRL_CLEAR_BIT  = 1;
  localparam int unsigned CTRL_IRQ_EN_BIT = 2;

  // Status register bits
  localparam int unsigned STAT_MATCH_BIT = 0;

  // AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // Slave protocol states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE_DATA,
    ST_WRITE_RESP,
    ST_READ_ACCESS,
    ST_READ_RESP
  } slave_state_e;

  // One register write from the slave
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } reg_wr_t;

  // Register bank answer to one read
  typedef struct packed {
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } reg_rd_t;

endpackage

//--- axil_periph_top.sv
module axil_periph_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_awvalid,
  output logic                                o_awready,
  input  logic [axil_periph_pkg::ADDR_W-1:0]  i_awaddr,
  input  logic                                i_wvalid,
  output logic                                o_wready,
  input  logic [axil_periph_pkg::DATA_W-1:0]  i_wdata,
  input  logic [axil_periph_pkg::STRB_W-1:0]  i_wstrb,
  output logic                                o_bvalid,
  input  logic                                i_bready,
  output axil_periph_pkg::axi_resp_e          o_bresp,
  input  logic                                i_arvalid,
  output logic                                o_arready,
  input  logic [axil_periph_pkg::ADDR_W-1:0]  i_araddr,
  output logic                                o_rvalid,
  input  logic                                i_rready,
  output logic [axil_periph_pkg::DATA_W-1:0]  o_rdata,
  output axil_periph_pkg::axi_resp_e          o_rresp,
  // Match interrupt
  output logic                                o_irq
);

  import axil_periph_pkg::*;

  // Slave to register bank
  logic              wr_stb;
  reg_wr_t           wr;
  axi_resp_e         wr_resp;
  logic [ADDR_W-1:0] rd_addr;
  reg_rd_t           rd;
  // Register bank to counter
  logic              count_en;
  logic              cnt_clear;
  logic [DATA_W-1:0] compare_val;
  logic [DATA_W-1:0] count;
  logic              match;

  axil_slave u_slave (
    .clk       (clk),
    .rst       (rst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_wr_stb  (wr_stb),
    .o_wr      (wr),
    .i_wr_resp (wr_resp),
    // Reads have no side effects in the register bank
    .o_rd_stb  (),
    .o_rd_addr (rd_addr),
    .i_rd      (rd)
  );

  reg_bank u_regs (
    .clk         (clk),
    .rst         (rst),
    .i_wr_stb    (wr_stb),
    .i_wr        (wr),
    .o_wr_resp   (wr_resp),
    .i_rd_addr   (rd_addr),
    .o_rd        (rd),
    .i_count     (count),
    .i_match     (match),
    .o_count_en  (count_en),
    .o_cnt_clear (cnt_clear),
    .o_compare   (compare_val),
    .o_irq       (o_irq)
  );

  event_counter u_counter (
    .clk       (clk),
    .rst       (rst),
    .i_en      (count_en),
    .i_clear   (cnt_clear),
    .i_compare (compare_val),
    .o_count   (count),
    .o_match   (match)
  );

endmodule

//--- axil_slave.sv
module axil_slave (
  input  logic                                clk,
  input  logic                                rst,
  // Write address channel
  input  logic                                i_awvalid,
  output logic                                o_awready,
  input  logic [axil_periph_pkg::ADDR_W-1:0]  i_awaddr,
  // Write data channel
  input  logic                                i_wvalid,
  output logic                                o_wready,
  input  logic [axil_periph_pkg::DATA_W-1:0]  i_wdata,
  input  logic [axil_periph_pkg::STRB_W-1:0]  i_wstrb,
  // Write response channel
  output logic                                o_bvalid,
  input  logic                                i_bready,
  output axil_periph_pkg::axi_resp_e          o_bresp,
  // Read address channel
  input  logic                                i_arvalid,
  output logic                                o_arready,
  input  logic [axil_periph_pkg::ADDR_W-1:0]  i_araddr,
  // Read data channel
  output logic                                o_rvalid,
  input  logic                                i_rready,
  output logic [axil_periph_pkg::DATA_W-1:0]  o_rdata,
  output axil_periph_pkg::axi_resp_e          o_rresp,
  // Register bank side
  output logic                                o_wr_stb,
  output axil_periph_pkg::reg_wr_t            o_wr,
  input  axil_periph_pkg::axi_resp_e          i_wr_resp,
  output logic                                o_rd_stb,
  output logic [axil_periph_pkg::ADDR_W-1:0]  o_rd_addr,
  input  axil_periph_pkg::reg_rd_t            i_rd
);

  import axil_periph_pkg::*;

  slave_state_e      state;
  logic [ADDR_W-1:0] addr_q;
  logic              aw_hs;
  logic              ar_hs;
  logic              w_hs;

  // Channel handshakes, write wins a tie with read
  assign aw_hs = (state == ST_IDLE) && i_awvalid && o_awready;
  assign ar_hs = (state == ST_IDLE) && i_arvalid && o_arready && !aw_hs;
  assign w_hs  = (state == ST_WRITE_DATA) && i_wvalid && o_wready;

  // Register access strobes
  assign o_wr_stb  = w_hs;
  assign o_rd_stb  = (state == ST_READ_ACCESS);
  assign o_rd_addr = addr_q;
  // Write payload goes straight through with the latched address
  assign o_wr = '{addr: addr_q, data: i_wdata, strb: i_wstrb};

  // Handshake FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      o_awready <= 1'b0;
      o_arready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw_hs) begin
            // Close both address channels for the whole write
            o_awready <= 1'b0;
            o_arready <= 1'b0;
            o_wready  <= 1'b1;
            state     <= ST_WRITE_DATA;
          end else if (ar_hs) begin
            o_awready <= 1'b0;
            o_arready <= 1'b0;
            state     <= ST_READ_ACCESS;
          end else begin
            o_awready <= 1'b1;
            o_arready <= 1'b1;
          end
        end
        ST_WRITE_DATA: begin
          // Register write happens on this edge
          if (w_hs) begin
            o_wready <= 1'b0;
            o_bvalid <= 1'b1;
            state    <= ST_WRITE_RESP;
          end
        end
        ST_WRITE_RESP: begin
          // Hold bvalid until the master takes it
          if (i_bready) begin
            o_bvalid  <= 1'b0;
            o_awready <= 1'b1;
            o_arready <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        ST_READ_ACCESS: begin
          // Read data captured this cycle
          o_rvalid <= 1'b1;
          state    <= ST_READ_RESP;
        end
        ST_READ_RESP: begin
          if (i_rready) begin
            o_rvalid  <= 1'b0;
            o_awready <= 1'b1;
            o_arready <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and response payloads
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      addr_q <= i_awaddr;
    end else if (ar_hs) begin
      addr_q <= i_araddr;
    end
    // Response code of the write just done
    if (o_wr_stb) begin
      o_bresp <= i_wr_resp;
    end
    // Read data and code held until the R transfer
    if (o_rd_stb) begin
      o_rdata <= i_rd.data;
      o_rresp <= i_rd.resp;
    end
  end

endmodule

//--- event_counter.sv
module event_counter (
  input  logic                                clk,
  input  logic                                rst,
  // Count enable level
  input  logic                                i_en,
  // Single cycle clear pulse
  input  logic                                i_clear,
  input  logic [axil_periph_pkg::DATA_W-1:0]  i_compare,
  output logic [axil_periph_pkg::DATA_W-1:0]  o_count,
  output logic                                o_match
);

  import axil_periph_pkg::*;

  logic [DATA_W-1:0] count_next;
  logic              count_hit;

  // Next count value, wraps at full width
  assign count_next = o_count + 1'b1;

  // Current count sits on the compare value
  assign count_hit = (o_count == i_compare);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_count <= '0;
      o_match <= 1'b0;
    end else if (i_clear) begin
      // Clear beats counting
      o_count <= '0;
      o_match <= 1'b0;
    end else if (i_en) begin
      o_count <= count_next;
      // Sticky until the next clear
      if (count_hit) begin
        o_match <= 1'b1;
      end
    end
  end

endmodule

//--- reg_bank.sv
module reg_bank (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_wr_stb,
  input  axil_periph_pkg::reg_wr_t            i_wr,
  output axil_periph_pkg::axi_resp_e          o_wr_resp,
  input  logic [axil_periph_pkg::ADDR_W-1:0]  i_rd_addr,
  output axil_periph_pkg::reg_rd_t            o_rd,
  input  logic [axil_periph_pkg::DATA_W-1:0]  i_count,
  input  logic                                i_match,
  output logic                                o_count_en,
  output logic                                o_cnt_clear,
  output logic [axil_periph_pkg::DATA_W-1:0]  o_compare,
  output logic                                o_irq
);

  import axil_periph_pkg::*;

  logic [DATA_W-1:0] control_q;
  logic [DATA_W-1:0] compare_q;
  logic [DATA_W-1:0] control_next;
  logic              hit_control;
  logic              hit_compare;

  // Replace only the bytes whose strobe is set
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
                                                    input logic [DATA_W-1:0] new_val,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] result;
    result = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return result;
  endfunction

  // Write decode, only two writable registers
  assign hit_control = (i_wr.addr == ADDR_CONTROL);
  assign hit_compare = (i_wr.addr == ADDR_COMPARE);
  assign o_wr_resp   = (hit_control || hit_compare) ? RESP_OKAY : RESP_DECERR;

  // Clear bit is a pulse and never stored
  always_comb begin
    control_next                 = merge_bytes(control_q, i_wr.data, i_wr.strb);
    control_next[CTRL_CLEAR_BIT] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      control_q   <= '0;
      compare_q   <= '0;
      o_cnt_clear <= 1'b0;
      o_irq       <= 1'b0;
    end else begin
      if (i_wr_stb && hit_control) begin
        control_q <= control_next;
      end
      if (i_wr_stb && hit_compare) begin
        compare_q <= merge_bytes(compare_q, i_wr.data, i_wr.strb);
      end
      // One cycle clear when byte 0 is written with bit 1 set
      o_cnt_clear <= i_wr_stb && hit_control && i_wr.strb[0] && i_wr.data[CTRL_CLEAR_BIT];
      // Interrupt follows match one cycle late
      o_irq <= i_match && control_q[CTRL_IRQ_EN_BIT];
    end
  end

  assign o_count_en = control_q[CTRL_EN_BIT];
  assign o_compare  = compare_q;

  // Read mux, unmapped reads give zero data
  always_comb begin
    o_rd.data = '0;
    o_rd.resp = RESP_OKAY;
    case (i_rd_addr)
      ADDR_CONTROL: o_rd.data = control_q;
      ADDR_STATUS:  o_rd.data[STAT_MATCH_BIT] = i_match;
      ADDR_COMPARE: o_rd.data = compare_q;
      ADDR_COUNT:   o_rd.data = i_count;
      default:      o_rd.resp = RESP_DECERR;
    endcase
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI4-Lite peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_periph -Mdir obj_dir -f axil_periph.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_axil_periph
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit 1
fi

echo "Simulation finished without errors"
exit 0

//--- tb_axil_periph.sv
module tb_axil_periph;

  timeunit 1ns;
  timeprecision 100ps;

  import axil_periph_pkg::*;

  // Run length limit in clock cycles
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  localparam logic [ADDR_W-1:0] ADDR_UNMAPPED = 32'h0000_0010;

  logic              clk;
  logic              rst;
  logic              i_awvalid;
  logic              o_awready;
  logic [ADDR_W-1:0] i_awaddr;
  logic              i_wvalid;
  logic              o_wready;
  logic [DATA_W-1:0] i_wdata;
  logic [STRB_W-1:0] i_wstrb;
  logic              o_bvalid;
  logic              i_bready;
  axi_resp_e         o_bresp;
  logic              i_arvalid;
  logic              o_arready;
  logic [ADDR_W-1:0] i_araddr;
  logic              o_rvalid;
  logic              i_rready;
  logic [DATA_W-1:0] o_rdata;
  axi_resp_e         o_rresp;
  logic              o_irq;

  // Register model
  logic [DATA_W-1:0] ctrl_m;
  logic [DATA_W-1:0] cmp_m;
  // Expected responses, armed by the check tasks
  logic              wr_check;
  logic              rd_check;
  axi_resp_e         exp_bresp;
  axi_resp_e         exp_rresp;
  logic [DATA_W-1:0] exp_rdata;
  // Previous-cycle copies for the protocol checks
  logic              rst_d;
  logic              ar_take;
  logic              ar_d1;
  logic              ar_d2;
  logic              b_stall;
  logic              r_stall;
  axi_resp_e         bresp_q;
  axi_resp_e         rresp_q;
  logic [DATA_W-1:0] rdata_q;
  int unsigned       cycles;

  axil_periph_top u_axil_periph_top (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic fail_check(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_check("Simulation timed out before all tests finished");
    end
  end

  // AR is ignored by the slave when AW is taken on the same edge
  assign ar_take = i_arvalid && o_arready && !(i_awvalid && o_awready);

  always @(posedge clk) begin
    rst_d   <= rst;
    ar_d1   <= ar_take && !rst;
    ar_d2   <= ar_d1;
    b_stall <= o_bvalid && !i_bready;
    r_stall <= o_rvalid && !i_rready;
    bresp_q <= o_bresp;
    rresp_q <= o_rresp;
    rdata_q <= o_rdata;
  end

  // Everything idle right after a reset edge
  assert property (@(posedge clk) rst_d |->
      !(o_awready || o_arready || o_wready || o_bvalid || o_rvalid || o_irq))
    else fail_check($sformatf("error reset outputs: aw %h ar %h w %h b %h r %h irq %h",
        $sampled(o_awready), $sampled(o_arready), $sampled(o_wready),
        $sampled(o_bvalid), $sampled(o_rvalid), $sampled(o_irq)));

  // B held steady while the master stalls
  assert property (@(posedge clk) disable iff (rst)
      b_stall |-> o_bvalid && o_bresp == bresp_q)
    else fail_check($sformatf("error o_bvalid/o_bresp: got %h/%h expected 1/%h",
        $sampled(o_bvalid), $sampled(o_bresp), $sampled(bresp_q)));

  // R held steady while the master stalls
  assert property (@(posedge clk) disable iff (rst)
      r_stall |-> o_rvalid && o_rdata == rdata_q && o_rresp == rresp_q)
    else fail_check($sformatf("error o_rvalid/o_rdata/o_rresp: got %h/%h/%h expected 1/%h/%h",
        $sampled(o_rvalid), $sampled(o_rdata), $sampled(o_rresp),
        $sampled(rdata_q), $sampled(rresp_q)));

  // Read data two cycles after the AR transfer, not earlier
  assert property (@(posedge clk) disable iff (rst) ar_d1 |-> !o_rvalid)
    else fail_check($sformatf("error o_rvalid: got %h expected 0", $sampled(o_rvalid)));
  assert property (@(posedge clk) disable iff (rst) ar_d2 |-> o_rvalid)
    else fail_check($sformatf("error o_rvalid: got %h expected 1", $sampled(o_rvalid)));

  assert property (@(posedge clk) disable iff (rst)
      wr_check && o_bvalid && i_bready |-> o_bresp == exp_bresp)
    else fail_check($sformatf("error o_bresp: got %h expected %h",
        $sampled(o_bresp), $sampled(exp_bresp)));

  assert property (@(posedge clk) disable iff (rst)
      rd_check && o_rvalid && i_rready |-> o_rdata == exp_rdata && o_rresp == exp_rresp)
    else fail_check($sformatf("error o_rdata/o_rresp: got %h/%h expected %h/%h",
        $sampled(o_rdata), $sampled(o_rresp), $sampled(exp_rdata), $sampled(exp_rresp)));

  // Byte lanes with a strobe take the new value
  function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old_val,
                                                      input logic [DATA_W-1:0] new_val,
                                                      input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < STRB_W; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    int unsigned stall;
    stall = $urandom_range(0, 4);
    @(posedge clk);
    i_awvalid <= 1'b1;
    i_awaddr  <= addr;
    @(negedge clk);
    while (!o_awready) @(negedge clk);
    @(posedge clk);
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b1;
    i_wdata   <= data;
    i_wstrb   <= strb;
    @(negedge clk);
    while (!o_wready) @(negedge clk);
    @(posedge clk);
    i_wvalid <= 1'b0;
    // Random back-pressure on B
    repeat (stall) @(posedge clk);
    i_bready <= 1'b1;
    @(negedge clk);
    while (!o_bvalid) @(negedge clk);
    @(posedge clk);
    i_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output axi_resp_e resp);
    int unsigned stall;
    stall = $urandom_range(0, 4);
    @(posedge clk);
    i_arvalid <= 1'b1;
    i_araddr  <= addr;
    @(negedge clk);
    while (!(o_arready && !(i_awvalid && o_awready))) @(negedge clk);
    @(posedge clk);
    i_arvalid <= 1'b0;
    repeat (stall) @(posedge clk);
    i_rready <= 1'b1;
    @(negedge clk);
    while (!o_rvalid) @(negedge clk);
    data = o_rdata;
    resp = o_rresp;
    @(posedge clk);
    i_rready <= 1'b0;
  endtask

  task automatic check_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb, input axi_resp_e resp);
    exp_bresp = resp;
    wr_check  = 1'b1;
    axi_write(addr, data, strb);
    wr_check  = 1'b0;
  endtask

  task automatic check_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input axi_resp_e resp);
    logic [DATA_W-1:0] got_data;
    axi_resp_e         got_resp;
    exp_rdata = data;
    exp_rresp = resp;
    rd_check  = 1'b1;
    axi_read(addr, got_data, got_resp);
    rd_check  = 1'b0;
  endtask

  // Model update, then a write that must answer OKAY
  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    if (addr == ADDR_CONTROL) begin
      ctrl_m = apply_strobes(ctrl_m, data, strb);
      ctrl_m[CTRL_CLEAR_BIT] = 1'b0;
    end else begin
      cmp_m = apply_strobes(cmp_m, data, strb);
    end
    check_write(addr, data, strb, RESP_OKAY);
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] n;
    logic [DATA_W-1:0] count_now;
    logic [DATA_W-1:0] count_prev;
    logic [DATA_W-1:0] status;
    axi_resp_e         resp;
    logic              seen;
    rst       <= 1'b1;
    i_awvalid <= 1'b0;
    i_awaddr  <= '0;
    i_wvalid  <= 1'b0;
    i_wdata   <= '0;
    i_wstrb   <= '0;
    i_bready  <= 1'b0;
    i_arvalid <= 1'b0;
    i_araddr  <= '0;
    i_rready  <= 1'b0;
    ctrl_m    = '0;
    cmp_m     = '0;
    wr_check  = 1'b0;
    rd_check  = 1'b0;
    rst_d     <= 1'b0;
    cycles    <= 0;
    void'($urandom(32'h688));
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    check_read(ADDR_CONTROL, '0, RESP_OKAY);
    check_read(ADDR_COMPARE, '0, RESP_OKAY);

    // Random strobed writes, each read back
    repeat (12) begin
      addr = ($urandom_range(0, 1) == 0) ? ADDR_CONTROL : ADDR_COMPARE;
      data = $urandom;
      model_write(addr, data, 4'($urandom_range(0, 15)));
      check_read(addr, (addr == ADDR_CONTROL) ? ctrl_m : cmp_m, RESP_OKAY);
    end

    // Read-only and unmapped addresses
    check_write(ADDR_STATUS, $urandom, 4'hF, RESP_DECERR);
    check_write(ADDR_COUNT, $urandom, 4'hF, RESP_DECERR);
    check_write(ADDR_UNMAPPED, $urandom, 4'hF, RESP_DECERR);
    check_read(ADDR_UNMAPPED, '0, RESP_DECERR);
    check_read(ADDR_CONTROL, ctrl_m, RESP_OKAY);
    check_read(ADDR_COMPARE, cmp_m, RESP_OKAY);

    // Count up to a small compare value with irq enabled
    // Compare sits above the count of the first poll round
    n = $urandom_range(16, 31);
    model_write(ADDR_COMPARE, n, 4'hF);
    model_write(ADDR_CONTROL, 32'h2, 4'hF);
    model_write(ADDR_CONTROL, 32'h5, 4'hF);
    count_prev = '0;
    seen       = 1'b0;
    while (!seen) begin
      axi_read(ADDR_COUNT, count_now, resp);
      axi_read(ADDR_STATUS, status, resp);
      seen = status[0];
      if (!seen) begin
        assert (count_now <= n)
          else fail_check($sformatf("error count: got %h limit %h", count_now, n));
      end
      assert (count_now > count_prev)
        else fail_check($sformatf("error count: got %h after %h", count_now, count_prev));
      count_prev = count_now;
    end
    @(negedge clk);
    assert (o_irq) else fail_check($sformatf("error o_irq: got %h expected 1", o_irq));

    // Clear and stop counting in one write, irq enable stays on
    model_write(ADDR_CONTROL, 32'h6, 4'hF);
    repeat (2) @(negedge clk);
    assert (!o_irq) else fail_check($sformatf("error o_irq: got %h expected 0", o_irq));
    check_read(ADDR_COUNT, '0, RESP_OKAY);
    check_read(ADDR_STATUS, '0, RESP_OKAY);

    // AW and AR offered together, write goes first
    data  = ~cmp_m;
    cmp_m = data;
    fork
      check_write(ADDR_COMPARE, data, 4'hF, RESP_OKAY);
      check_read(ADDR_COMPARE, data, RESP_OKAY);
    join

    $display("TEST OK");
    $finish;
  end

endmodule
